// File: filelist.f
logic/slurm16_pkg.sv
logic/slurm16_cpu_memory_interface.sv
logic/slurm16_memory_arbiter.sv
logic/slurm16_block_ram.sv
logic/slurm16_memory_subsystem.sv
tb/tb_clock_gen.sv
tb/tb_slurm16_memory.sv

// File: logic/slurm16_block_ram.sv
/*
 * Single-port synchronous block RAM with a byte write mask
 * and a registered read word, read before write
 */

`timescale 1ns/1ps

module slurm16_block_ram (
	input  logic                                      CLK,
	input  logic [slurm16_pkg::ram_depth_bits - 1 : 0] ram_address,
	input  logic [slurm16_pkg::word_bits - 1 : 0]      ram_wr_data,
	input  logic [1:0]                                ram_wr_mask,
	input  logic                                      ram_wr,
	output logic [slurm16_pkg::word_bits - 1 : 0]      ram_rd_data
);

	localparam int depth = 1 << slurm16_pkg::ram_depth_bits;

	slurm16_pkg::mem_word_u mem [0 : depth - 1];
	slurm16_pkg::mem_word_u wr_word;

	assign wr_word.word = ram_wr_data;	// Byte view of the incoming word

	// Masked byte writes
	always_ff @(posedge CLK) begin
		if (ram_wr) begin
			for (int i = 0; i < slurm16_pkg::word_bytes; i++) begin
				if (ram_wr_mask[i])
					mem[ram_address].bytes[i] <= wr_word.bytes[i];
			end
		end
	end

	// Registered read, returns the old word during a write
	always_ff @(posedge CLK) begin
		ram_rd_data <= mem[ram_address].word;
	end

	// A write strobe with no byte enabled does nothing, likely a caller bug
	a_wr_mask_nonzero: assert property (@(posedge CLK)
			ram_wr |-> ram_wr_mask != 2'b00)
		else $warning("RAM write with empty byte mask");

endmodule

// File: logic/slurm16_cpu_memory_interface.sv
/*
 * CPU memory interface: merges the instruction fetch and data ports
 * into one two-stage pipelined memory request, data port first,
 * and splits the returned success flag back per port
 */

`timescale 1ns/1ps

module slurm16_cpu_memory_interface (
	input  logic                                    CLK,
	input  logic                                    RSTb,

	// Instruction port
	input  logic [slurm16_pkg::address_bits - 2 : 0] instruction_memory_address,
	input  logic                                    instruction_memory_read_req,
	output logic [slurm16_pkg::word_bits - 1 : 0]    instruction_memory_data,
	output logic [slurm16_pkg::address_bits - 2 : 0] instruction_memory_address_out,
	output logic                                    instruction_memory_success,

	// Data port
	input  logic [slurm16_pkg::address_bits - 1 : 0] data_memory_address,
	input  logic [slurm16_pkg::word_bits - 1 : 0]    data_memory_in,
	input  logic                                    data_memory_read_req,
	input  logic                                    data_memory_write_req,
	input  logic [1:0]                              data_memory_wr_mask,
	output logic [slurm16_pkg::word_bits - 1 : 0]    data_memory_data_out,
	output logic                                    data_memory_success,
	output logic [1:0]                              data_memory_wr_mask_out,

	// Towards the arbiter
	output logic [slurm16_pkg::address_bits - 1 : 0] memory_address,
	output logic [slurm16_pkg::word_bits - 1 : 0]    data_out,
	output logic [1:0]                              wr_mask,
	output logic                                    mem_wr,
	output logic                                    cpu_req,
	input  logic [slurm16_pkg::word_bits - 1 : 0]    data_in,
	input  logic                                    memory_success
);

	// Flag bit positions in the stage registers
	localparam int flag_rd  = 0;	// 1 = read, 0 = write
	localparam int flag_ins = 1;	// 1 = instruction, 0 = data
	localparam int flag_req = 2;	// 1 = request present

	logic [slurm16_pkg::address_bits - 1 : 0] address_stage_1, address_stage_1_next;
	logic [slurm16_pkg::word_bits - 1 : 0]    data_stage_1, data_stage_1_next;
	logic [2:0]                              flags_stage_1, flags_stage_1_next;
	logic [1:0]                              mask_stage_1, mask_stage_1_next;

	logic [slurm16_pkg::address_bits - 1 : 0] address_stage_2;
	logic [2:0]                              flags_stage_2;
	logic [1:0]                              mask_stage_2;

	// Data port wins over instruction fetch
	always_comb begin
		address_stage_1_next = address_stage_1;	// Hold address and data when idle
		data_stage_1_next    = data_stage_1;
		flags_stage_1_next   = 3'b000;
		mask_stage_1_next    = 2'b00;

		if (data_memory_read_req || data_memory_write_req) begin
			address_stage_1_next         = data_memory_address;
			data_stage_1_next            = data_memory_in;
			flags_stage_1_next[flag_rd]  = data_memory_read_req;	// Read wins if both are set
			flags_stage_1_next[flag_ins] = 1'b0;
			flags_stage_1_next[flag_req] = 1'b1;
			mask_stage_1_next            = data_memory_wr_mask;
		end else if (instruction_memory_read_req) begin
			address_stage_1_next         = {1'b0, instruction_memory_address};	// Fetches live in the low half
			flags_stage_1_next[flag_rd]  = 1'b1;
			flags_stage_1_next[flag_ins] = 1'b1;
			flags_stage_1_next[flag_req] = 1'b1;
		end
	end

	// Stage 1 holds the request presented to the arbiter
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			address_stage_1 <= '0;
			data_stage_1    <= '0;
			flags_stage_1   <= 3'b000;
			mask_stage_1    <= 2'b00;
		end else begin
			address_stage_1 <= address_stage_1_next;
			data_stage_1    <= data_stage_1_next;
			flags_stage_1   <= flags_stage_1_next;
			mask_stage_1    <= mask_stage_1_next;
		end
	end

	// Stage 2 lines up with the registered RAM word
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			address_stage_2 <= '0;
			flags_stage_2   <= 3'b000;
			mask_stage_2    <= 2'b00;
		end else begin
			address_stage_2 <= address_stage_1;
			flags_stage_2   <= flags_stage_1;
			mask_stage_2    <= mask_stage_1;
		end
	end

	assign memory_address = address_stage_1;
	assign data_out       = data_stage_1;
	assign wr_mask        = mask_stage_1;
	assign cpu_req        = flags_stage_1[flag_req];
	assign mem_wr         = flags_stage_1[flag_req] && !flags_stage_1[flag_ins]
			&& !flags_stage_1[flag_rd];

	// Read data always shows the RAM word whether valid or not
	assign instruction_memory_data = data_in;
	assign data_memory_data_out    = data_in;

	assign instruction_memory_address_out = address_stage_2[slurm16_pkg::address_bits - 2 : 0];
	assign data_memory_wr_mask_out        = mask_stage_2;

	assign instruction_memory_success = flags_stage_2[flag_req] && flags_stage_2[flag_ins]
			&& memory_success;
	assign data_memory_success        = flags_stage_2[flag_req] && !flags_stage_2[flag_ins]
			&& memory_success;

	// A write leaving stage 1 was asked for by the data port one edge earlier
	a_wr_from_data_port: assert property (@(posedge CLK) disable iff (!RSTb)
			mem_wr |-> $past(data_memory_write_req) && !$past(data_memory_read_req))
		else $error("mem_wr without a data write request");

	// Each success traces back to the port that won the select two edges earlier
	a_fetch_success: assert property (@(posedge CLK) disable iff (!RSTb)
			instruction_memory_success |-> $past(instruction_memory_read_req, 2)
			&& !$past(data_memory_read_req || data_memory_write_req, 2))
		else $error("instruction success without a winning fetch");

	a_data_success: assert property (@(posedge CLK) disable iff (!RSTb)
			data_memory_success |-> $past(data_memory_read_req || data_memory_write_req, 2))
		else $error("data success without a data request");

endmodule

// File: logic/slurm16_memory_arbiter.sv
/*
 * Memory arbiter: shares the block RAM between the CPU pipeline
 * and a read-only auxiliary port, auxiliary first
 */

`timescale 1ns/1ps

module slurm16_memory_arbiter (
	input  logic                                      CLK,
	input  logic                                      RSTb,

	// CPU pipeline, stage 1
	input  logic                                      cpu_req,
	input  logic [slurm16_pkg::address_bits - 1 : 0]   memory_address,
	input  logic [slurm16_pkg::word_bits - 1 : 0]      data_out,
	input  logic [1:0]                                wr_mask,
	input  logic                                      mem_wr,
	output logic                                      memory_success,

	// Auxiliary read port
	input  logic                                      aux_read_req,
	input  logic [slurm16_pkg::address_bits - 1 : 0]   aux_address,
	output logic                                      aux_success,
	output logic [slurm16_pkg::word_bits - 1 : 0]      aux_data,

	// Block RAM
	output logic [slurm16_pkg::ram_depth_bits - 1 : 0] ram_address,
	output logic [slurm16_pkg::word_bits - 1 : 0]      ram_wr_data,
	output logic [1:0]                                ram_wr_mask,
	output logic                                      ram_wr,
	input  logic [slurm16_pkg::word_bits - 1 : 0]      ram_rd_data
);

	logic aux_grant;
	logic cpu_grant;

	assign aux_grant = aux_read_req;
	assign cpu_grant = cpu_req && !aux_read_req;	// CPU only gets the leftover cycles

	// Only the low address bits reach the RAM
	assign ram_address = aux_grant ? aux_address[slurm16_pkg::ram_depth_bits - 1 : 0]
			: memory_address[slurm16_pkg::ram_depth_bits - 1 : 0];

	// A losing CPU write is dropped here
	assign ram_wr      = mem_wr && cpu_grant;
	assign ram_wr_data = data_out;
	assign ram_wr_mask = wr_mask;

	// RAM word goes to the aux port as is
	assign aux_data = ram_rd_data;

	// Grant outcome registered alongside the RAM read word
	always_ff @(posedge CLK) begin
		if (!RSTb) begin
			memory_success <= 1'b0;
			aux_success    <= 1'b0;
		end else begin
			memory_success <= cpu_grant;
			aux_success    <= aux_grant;
		end
	end

	// A CPU write strobe always comes with its request
	a_wr_is_cpu_grant: assert property (@(posedge CLK) disable iff (!RSTb)
			mem_wr |-> cpu_req)
		else $error("CPU write strobe without a CPU request");

endmodule

// File: logic/slurm16_memory_subsystem.sv
/*
 * Memory subsystem top: CPU memory interface, arbiter and block RAM
 */

`timescale 1ns/1ps

module slurm16_memory_subsystem (
	input  logic                                    CLK,
	input  logic                                    RSTb,

	// CPU instruction port
	input  logic [slurm16_pkg::address_bits - 2 : 0] instruction_memory_address,
	input  logic                                    instruction_memory_read_req,
	output logic [slurm16_pkg::word_bits - 1 : 0]    instruction_memory_data,
	output logic [slurm16_pkg::address_bits - 2 : 0] instruction_memory_address_out,
	output logic                                    instruction_memory_success,

	// CPU data port
	input  logic [slurm16_pkg::address_bits - 1 : 0] data_memory_address,
	input  logic [slurm16_pkg::word_bits - 1 : 0]    data_memory_in,
	input  logic                                    data_memory_read_req,
	input  logic                                    data_memory_write_req,
	input  logic [1:0]                              data_memory_wr_mask,
	output logic [slurm16_pkg::word_bits - 1 : 0]    data_memory_data_out,
	output logic                                    data_memory_success,
	output logic [1:0]                              data_memory_wr_mask_out,

	// Auxiliary read port
	input  logic                                    aux_read_req,
	input  logic [slurm16_pkg::address_bits - 1 : 0] aux_address,
	output logic [slurm16_pkg::word_bits - 1 : 0]    aux_data,
	output logic                                    aux_success
);

	// CPU pipeline to arbiter
	logic [slurm16_pkg::address_bits - 1 : 0]   memory_address;
	logic [slurm16_pkg::word_bits - 1 : 0]      data_out;
	logic [1:0]                                wr_mask;
	logic                                      mem_wr;
	logic                                      cpu_req;
	logic                                      memory_success;

	// Arbiter to RAM
	logic [slurm16_pkg::ram_depth_bits - 1 : 0] ram_address;
	logic [slurm16_pkg::word_bits - 1 : 0]      ram_wr_data;
	logic [1:0]                                ram_wr_mask;
	logic                                      ram_wr;
	logic [slurm16_pkg::word_bits - 1 : 0]      ram_rd_data;

	slurm16_cpu_memory_interface u_cpu_if (
		.CLK                            (CLK),
		.RSTb                           (RSTb),
		.instruction_memory_address     (instruction_memory_address),
		.instruction_memory_read_req    (instruction_memory_read_req),
		.instruction_memory_data        (instruction_memory_data),
		.instruction_memory_address_out (instruction_memory_address_out),
		.instruction_memory_success     (instruction_memory_success),
		.data_memory_address            (data_memory_address),
		.data_memory_in                 (data_memory_in),
		.data_memory_read_req           (data_memory_read_req),
		.data_memory_write_req          (data_memory_write_req),
		.data_memory_wr_mask            (data_memory_wr_mask),
		.data_memory_data_out           (data_memory_data_out),
		.data_memory_success            (data_memory_success),
		.data_memory_wr_mask_out        (data_memory_wr_mask_out),
		.memory_address                 (memory_address),
		.data_out                       (data_out),
		.wr_mask                        (wr_mask),
		.mem_wr                         (mem_wr),
		.cpu_req                        (cpu_req),
		.data_in                        (ram_rd_data),	// RAM word straight to the CPU
		.memory_success                 (memory_success)
	);

	slurm16_memory_arbiter u_arbiter (
		.CLK            (CLK),
		.RSTb           (RSTb),
		.cpu_req        (cpu_req),
		.memory_address (memory_address),
		.data_out       (data_out),
		.wr_mask        (wr_mask),
		.mem_wr         (mem_wr),
		.memory_success (memory_success),
		.aux_read_req   (aux_read_req),
		.aux_address    (aux_address),
		.aux_success    (aux_success),
		.aux_data       (aux_data),
		.ram_address    (ram_address),
		.ram_wr_data    (ram_wr_data),
		.ram_wr_mask    (ram_wr_mask),
		.ram_wr         (ram_wr),
		.ram_rd_data    (ram_rd_data)
	);

	slurm16_block_ram u_ram (
		.CLK         (CLK),
		.ram_address (ram_address),
		.ram_wr_data (ram_wr_data),
		.ram_wr_mask (ram_wr_mask),
		.ram_wr      (ram_wr),
		.ram_rd_data (ram_rd_data)
	);

endmodule

// File: logic/slurm16_pkg.sv
/*
 * Shared widths and RAM depth for the slurm16 memory path,
 * and the word/byte union used by the block RAM
 */

package slurm16_pkg;

	// Data path width
	localparam int word_bits = 16;

	// Full CPU address width. The instruction port drops the top bit
	localparam int address_bits = 16;

	// Block RAM holds 2**ram_depth_bits words
	localparam int ram_depth_bits = 10;

	// Number of bytes in a word, one mask bit each
	localparam int word_bytes = word_bits / 8;

	/*
	 * One stored word, seen either whole or as bytes.
	 * bytes[0] aliases word[7:0], bytes[1] aliases word[15:8]
	 */
	typedef union packed {
		logic [word_bits - 1 : 0]       word;
		logic [word_bytes - 1 : 0][7:0] bytes;
	} mem_word_u;

endpackage

// File: run_verilator.sh
#!/bin/sh
# Build the memory subsystem testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert --top-module tb_slurm16_memory \
	-f filelist.f -o tb_slurm16_memory > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/tb_slurm16_memory > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "run_verilator: pass" || { echo "run_verilator: fail"; exit 1; }

// File: tb/memory_patterns.txt
# name ireq iaddr drd dwr daddr ddata dmask areq aaddr | cchk isucc dsucc eaddr emask eword | achk asucc aword
# All values hex. cchk 0 none, 1 flags, 2 flags and word. achk 0 none, 1 flag, 2 flag and word
idle_0     0 0000 0 0 0000 0000 0 0 0000  1 0 0 0000 0 0000  1 0 0000
idle_1     0 0000 0 0 0000 0000 0 0 0000  1 0 0 0000 0 0000  1 0 0000
# Full word write then read back
wr_full    0 0000 0 1 0010 a5c3 3 0 0000  1 0 1 0000 3 0000  1 0 0000
rd_full    0 0000 1 0 0010 0000 0 0 0000  2 0 1 0000 0 a5c3  1 0 0000
# Byte masked writes merge into one word
wr_base    0 0000 0 1 0020 1234 3 0 0000  1 0 1 0000 3 0000  1 0 0000
wr_lo      0 0000 0 1 0020 77ab 1 0 0000  1 0 1 0000 1 0000  1 0 0000
wr_hi      0 0000 0 1 0020 cd99 2 0 0000  1 0 1 0000 2 0000  1 0 0000
rd_merge   0 0000 1 0 0020 0000 0 0 0000  2 0 1 0000 0 cdab  1 0 0000
# Program words, then back to back fetches
wr_ins_0   0 0000 0 1 0030 1a00 3 0 0000  1 0 1 0000 3 0000  1 0 0000
wr_ins_1   0 0000 0 1 0031 1b01 3 0 0000  1 0 1 0000 3 0000  1 0 0000
wr_ins_2   0 0000 0 1 0032 1c02 3 0 0000  1 0 1 0000 3 0000  1 0 0000
fetch_0    1 0030 0 0 0000 0000 0 0 0000  2 1 0 0030 0 1a00  1 0 0000
fetch_1    1 0031 0 0 0000 0000 0 0 0000  2 1 0 0031 0 1b01  1 0 0000
fetch_2    1 0032 0 0 0000 0000 0 0 0000  2 1 0 0032 0 1c02  1 0 0000
# Data request beats a fetch in the same cycle
pri_rd     1 0031 1 0 0010 0000 0 0 0000  2 0 1 0000 0 a5c3  1 0 0000
pri_wr     1 0032 0 1 0050 5a5a 3 0 0000  1 0 1 0000 3 0000  1 0 0000
rd_pri_wr  0 0000 1 0 0050 0000 0 0 0000  2 0 1 0000 0 5a5a  1 0 0000
idle_2     0 0000 0 0 0000 0000 0 0 0000  1 0 0 0000 0 0000  1 0 0000
# Aux read with the RAM otherwise idle
aux_solo   0 0000 0 0 0000 0000 0 1 0020  1 0 0 0000 0 0000  2 1 cdab
idle_3     0 0000 0 0 0000 0000 0 0 0000  1 0 0 0000 0 0000  1 0 0000
# Aux read lands on the stage 1 slot of wr_blocked
wr_keep    0 0000 0 1 0040 1111 3 0 0000  1 0 1 0000 3 0000  1 0 0000
wr_blocked 0 0000 0 1 0040 beef 3 0 0000  1 0 0 0000 0 0000  1 0 0000
aux_win    0 0000 0 0 0000 0000 0 1 0010  1 0 0 0000 0 0000  2 1 a5c3
rd_keep    0 0000 1 0 0040 0000 0 0 0000  2 0 1 0000 0 1111  1 0 0000
idle_4     0 0000 0 0 0000 0000 0 0 0000  1 0 0 0000 0 0000  1 0 0000
idle_5     0 0000 0 0 0000 0000 0 0 0000  1 0 0 0000 0 0000  1 0 0000

// File: tb/tb_clock_gen.sv
/*
 * Testbench clock and reset source, 4 ns clock period,
 * reset held low for the first 10 rising edges
 */

`timescale 1ns/1ps

module tb_clock_gen (
	output logic CLK,
	output logic RSTb
);

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;	// 250 MHz
	end

	initial begin
		RSTb = 1'b0;
		repeat (10) @(posedge CLK);
		#1 RSTb = 1'b1;	// Released just after the 10th edge
	end

endmodule

// File: tb/tb_slurm16_memory.sv
/*
 * Testbench for the slurm16 memory subsystem, replays per-cycle
 * patterns from tb/memory_patterns.txt and checks every result
 */

`timescale 1ns/1ps

module tb_slurm16_memory;

	localparam int max_lines   = 256;
	localparam int max_reads   = 1024;	// All file lines, comments included
	localparam int reset_limit = 40;
	localparam int drain_limit = 8;
	localparam int num_cols    = 18;

	// Pattern columns
	localparam int c_ireq  = 0;
	localparam int c_iaddr = 1;
	localparam int c_drd   = 2;
	localparam int c_dwr   = 3;
	localparam int c_daddr = 4;
	localparam int c_ddata = 5;
	localparam int c_dmask = 6;
	localparam int c_areq  = 7;
	localparam int c_aaddr = 8;
	localparam int c_cchk  = 9;	// 0 none, 1 flags, 2 flags and word
	localparam int c_isucc = 10;
	localparam int c_dsucc = 11;
	localparam int c_eaddr = 12;
	localparam int c_emask = 13;
	localparam int c_eword = 14;
	localparam int c_achk  = 15;	// 0 none, 1 flag, 2 flag and word
	localparam int c_asucc = 16;
	localparam int c_aword = 17;

	logic                                     CLK;
	logic                                     RSTb;
	logic [slurm16_pkg::address_bits - 2 : 0] instruction_memory_address;
	logic                                     instruction_memory_read_req;
	logic [slurm16_pkg::word_bits - 1 : 0]    instruction_memory_data;
	logic [slurm16_pkg::address_bits - 2 : 0] instruction_memory_address_out;
	logic                                     instruction_memory_success;
	logic [slurm16_pkg::address_bits - 1 : 0] data_memory_address;
	logic [slurm16_pkg::word_bits - 1 : 0]    data_memory_in;
	logic                                     data_memory_read_req;
	logic                                     data_memory_write_req;
	logic [1:0]                               data_memory_wr_mask;
	logic [slurm16_pkg::word_bits - 1 : 0]    data_memory_data_out;
	logic                                     data_memory_success;
	logic [1:0]                               data_memory_wr_mask_out;
	logic                                     aux_read_req;
	logic [slurm16_pkg::address_bits - 1 : 0] aux_address;
	logic [slurm16_pkg::word_bits - 1 : 0]    aux_data;
	logic                                     aux_success;

	string       names [0 : max_lines - 1];
	logic [15:0] col   [0 : max_lines - 1][0 : num_cols - 1];
	int          num_lines;
	int          cpu_q [$];	// Line numbers waiting for their CPU result
	int          aux_q [$];	// Line numbers waiting for their aux result

	tb_clock_gen u_clock_gen (
		.CLK  (CLK),
		.RSTb (RSTb)
	);

	slurm16_memory_subsystem u_dut (
		.CLK                            (CLK),
		.RSTb                           (RSTb),
		.instruction_memory_address     (instruction_memory_address),
		.instruction_memory_read_req    (instruction_memory_read_req),
		.instruction_memory_data        (instruction_memory_data),
		.instruction_memory_address_out (instruction_memory_address_out),
		.instruction_memory_success     (instruction_memory_success),
		.data_memory_address            (data_memory_address),
		.data_memory_in                 (data_memory_in),
		.data_memory_read_req           (data_memory_read_req),
		.data_memory_write_req          (data_memory_write_req),
		.data_memory_wr_mask            (data_memory_wr_mask),
		.data_memory_data_out           (data_memory_data_out),
		.data_memory_success            (data_memory_success),
		.data_memory_wr_mask_out        (data_memory_wr_mask_out),
		.aux_read_req                   (aux_read_req),
		.aux_address                    (aux_address),
		.aux_data                       (aux_data),
		.aux_success                    (aux_success)
	);

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("TEST FAILED");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_word(input string test, input string what,
			input slurm16_pkg::mem_word_u expected, input slurm16_pkg::mem_word_u actual);
		if (actual.word !== expected.word)
			abort_run($sformatf("error %s: %s expected %h actual %h (bytes %h %h)", test, what,
					expected.word, actual.word, actual.bytes[1], actual.bytes[0]));
	endtask

	task automatic check_flag(input string test, input string what,
			input logic expected, input logic actual);
		if (actual !== expected)
			abort_run($sformatf("error %s: %s expected %b actual %b", test, what,
					expected, actual));
	endtask

	task automatic check_address(input string test,
			input logic [slurm16_pkg::address_bits - 2 : 0] expected,
			input logic [slurm16_pkg::address_bits - 2 : 0] actual);
		if (actual !== expected)
			abort_run($sformatf("error %s: returned address expected %h actual %h", test,
					expected, actual));
	endtask

	task automatic check_mask(input string test, input logic [1:0] expected,
			input logic [1:0] actual);
		if (actual !== expected)
			abort_run($sformatf("error %s: returned mask expected %b actual %b", test,
					expected, actual));
	endtask

	task automatic wait_for_reset();
		int cycles;
		cycles = 0;
		while (RSTb !== 1'b1) begin
			if (cycles >= reset_limit)
				abort_run("timeout waiting for reset release");
			@(posedge CLK);
			cycles++;
		end
		@(posedge CLK);
		#1;
	endtask

	// Columns after the name are hex, lines starting with # are skipped
	task automatic load_patterns();
		int          fd;
		int          cnt;
		int          sp;
		int          reads;
		string       line;
		string       rest;
		logic [15:0] f [0 : num_cols - 1];
		fd = $fopen("tb/memory_patterns.txt", "r");
		if (fd == 0)
			abort_run("cannot open tb/memory_patterns.txt");
		num_lines = 0;
		reads     = 0;
		while (!$feof(fd)) begin
			if (reads >= max_reads || num_lines >= max_lines)
				abort_run("pattern file is longer than the testbench can hold");
			line = "";
			void'($fgets(line, fd));
			reads++;
			if (line.len() > 1 && line.getc(0) != "#") begin
				sp = 0;
				while (sp < line.len() && line.getc(sp) != " ")
					sp++;
				rest = line.substr(sp, line.len() - 1);
				cnt = $sscanf(rest, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
						f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
						f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16], f[17]);
				if (cnt != num_cols)
					abort_run($sformatf("pattern line %0d has %0d values", reads, cnt));
				names[num_lines] = line.substr(0, sp - 1);
				for (int c = 0; c < num_cols; c++)
					col[num_lines][c] = f[c];
				num_lines++;
			end
		end
		$fclose(fd);
	endtask

	task automatic drive_line(input int n);
		instruction_memory_read_req = col[n][c_ireq][0];
		instruction_memory_address  = col[n][c_iaddr][slurm16_pkg::address_bits - 2 : 0];
		data_memory_read_req        = col[n][c_drd][0];
		data_memory_write_req       = col[n][c_dwr][0];
		data_memory_address         = col[n][c_daddr];
		data_memory_in              = col[n][c_ddata];
		data_memory_wr_mask         = col[n][c_dmask][1:0];
		aux_read_req                = col[n][c_areq][0];
		aux_address                 = col[n][c_aaddr];
	endtask

	task automatic drive_idle();
		instruction_memory_read_req = 1'b0;
		instruction_memory_address  = '0;
		data_memory_read_req        = 1'b0;
		data_memory_write_req       = 1'b0;
		data_memory_address         = '0;
		data_memory_in              = '0;
		data_memory_wr_mask         = 2'b00;
		aux_read_req                = 1'b0;
		aux_address                 = '0;
	endtask

	task automatic check_cpu_result(input int n);
		string t;
		t = names[n];
		if (col[n][c_cchk] != 16'd0) begin
			check_flag(t, "instruction success", col[n][c_isucc][0], instruction_memory_success);
			check_flag(t, "data success", col[n][c_dsucc][0], data_memory_success);
			if (col[n][c_isucc][0])
				check_address(t, col[n][c_eaddr][slurm16_pkg::address_bits - 2 : 0],
						instruction_memory_address_out);
			if (col[n][c_dsucc][0])
				check_mask(t, col[n][c_emask][1:0], data_memory_wr_mask_out);
			if (col[n][c_cchk] == 16'd2 && col[n][c_dsucc][0])
				check_word(t, "data word", col[n][c_eword], data_memory_data_out);
			else if (col[n][c_cchk] == 16'd2)
				check_word(t, "instruction word", col[n][c_eword], instruction_memory_data);
		end
	endtask

	task automatic check_aux_result(input int n);
		if (col[n][c_achk] != 16'd0)
			check_flag(names[n], "aux success", col[n][c_asucc][0], aux_success);
		if (col[n][c_achk] == 16'd2)
			check_word(names[n], "aux word", col[n][c_aword], aux_data);
	endtask

	// CPU results are due two edges after the drive, aux results one edge
	task automatic run_due_checks(input int it);
		while (cpu_q.size() > 0 && cpu_q[0] + 2 == it)
			check_cpu_result(cpu_q.pop_front());
		while (aux_q.size() > 0 && aux_q[0] + 1 == it)
			check_aux_result(aux_q.pop_front());
	endtask

	initial begin
		int it;
		drive_idle();
		wait_for_reset();
		load_patterns();
		check_flag("reset", "instruction success", 1'b0, instruction_memory_success);
		check_flag("reset", "data success", 1'b0, data_memory_success);
		check_flag("reset", "aux success", 1'b0, aux_success);
		for (it = 0; it < num_lines; it++) begin
			run_due_checks(it);
			drive_line(it);
			cpu_q.push_back(it);
			aux_q.push_back(it);
			@(posedge CLK);
			#1;
		end
		drive_idle();
		while (cpu_q.size() > 0 || aux_q.size() > 0) begin
			if (it > num_lines + drain_limit)
				abort_run("timeout waiting for the last results");
			run_due_checks(it);
			it++;
			@(posedge CLK);
			#1;
		end
		$display("TEST PASSED");
		$finish;
	end

endmodule
